/* cpu_isa_pkg.sv */
/*
 * instruction set definitions: word widths, opcodes, alu and memory
 * operation codes, register and immediate instruction formats
 */
`default_nettype none

package cpu_isa_pkg;

    // data word and register file geometry
    localparam int XLEN   = 32;
    localparam int NREGS  = 32;
    localparam int REG_AW = 5;

    // major opcodes, top six bits of every instruction
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_t;

    // register form function, low three bits of func
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    // pass returns operand 1 untouched, no user yet
    typedef enum logic {
        EX_OUT_ALU,
        EX_OUT_PASS
    } ex_out_sel_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [10:0]       func;
    } r_form_t;

    // sw stores register rd at rs1 + imm
    typedef struct packed {
        opcode_t           opcode;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [15:0]       imm;
    } i_form_t;

    // one fetched word, two views
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_t;

endpackage

`default_nettype wire

/* cpu_pipe_pkg.sv */
/*
 * pipeline definitions: reset pc, bus address width, stage registers,
 * hazard record, write-back port and wishbone request and response
 */
`default_nettype none

package cpu_pipe_pkg;

    // word addresses on the bus
    localparam int ADDR_W = 16;
    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    // fetch register
    typedef struct packed {
        logic                        valid;
        logic [ADDR_W-1:0]           pc;
        cpu_isa_pkg::instr_t         instr;
    } if_id_t;

    // decode register, operands already read
    typedef struct packed {
        logic                              valid;
        cpu_isa_pkg::alu_op_t              alu_op;
        cpu_isa_pkg::ex_out_sel_t          ex_out_sel;
        logic [cpu_isa_pkg::XLEN-1:0]      alu_in0;
        logic [cpu_isa_pkg::XLEN-1:0]      alu_in1;
        cpu_isa_pkg::mem_op_t              mem_op;
        logic [cpu_isa_pkg::XLEN-1:0]      mem_wr_data;
        logic [cpu_isa_pkg::REG_AW-1:0]    dst_addr;
        logic                              gpr_we;
    } id_ex_t;

    // execute register
    typedef struct packed {
        logic                              valid;
        logic [cpu_isa_pkg::XLEN-1:0]      ex_out;
        cpu_isa_pkg::mem_op_t              mem_op;
        logic [cpu_isa_pkg::XLEN-1:0]      mem_wr_data;
        logic [cpu_isa_pkg::REG_AW-1:0]    dst_addr;
        logic                              gpr_we;
    } ex_mem_t;

    // pending writer seen by the decode interlock
    typedef struct packed {
        logic                              valid;
        logic [cpu_isa_pkg::REG_AW-1:0]    dst_addr;
        logic                              gpr_we;
    } hazard_t;

    typedef struct packed {
        logic                              we;
        logic [cpu_isa_pkg::REG_AW-1:0]    addr;
        logic [cpu_isa_pkg::XLEN-1:0]      data;
    } wb_wr_t;

    // wishbone classic, master side
    typedef struct packed {
        logic                              cyc;
        logic                              stb;
        logic                              we;
        logic [ADDR_W-1:0]                 adr;
        logic [cpu_isa_pkg::XLEN-1:0]      dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                              ack;
        logic [cpu_isa_pkg::XLEN-1:0]      dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* if_stage.sv */
/*
 * instruction fetch: sequential pc, one wishbone read at a time,
 * fetch register toward decode
 */
`default_nettype none

module if_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    halted,
    input  wire                    id_ready,
    output cpu_pipe_pkg::wb_req_t  bus_req,
    input  cpu_pipe_pkg::wb_rsp_t  bus_rsp,
    output cpu_pipe_pkg::if_id_t   if_id
);
    import cpu_pipe_pkg::*;

    logic              busy_q;
    logic [ADDR_W-1:0] pc_q;
    logic              ack;
    logic              slot_free;

    // ack only counts for our own open access
    assign ack = bus_rsp.ack && busy_q;
    // nothing can land in a full, stuck fetch register
    assign slot_free = !if_id.valid || id_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            pc_q   <= RESET_PC;
            if_id  <= '0;
        end else begin
            // stb stays low for one cycle after ack
            if (ack) begin
                busy_q <= 1'b0;
                pc_q   <= pc_q + 1'b1;
            end else if (!busy_q && slot_free && !halted) begin
                busy_q <= 1'b1;
            end
            if (ack) begin
                if_id.valid <= 1'b1;
                if_id.pc    <= pc_q;
                if_id.instr <= bus_rsp.dat_r;
            end else if (id_ready) begin
                if_id.valid <= 1'b0;
            end
        end
    end

    // read only, address is the pc itself
    assign bus_req.cyc   = busy_q;
    assign bus_req.stb   = busy_q;
    assign bus_req.we    = 1'b0;
    assign bus_req.adr   = pc_q;
    assign bus_req.dat_w = '0;

endmodule

`default_nettype wire

/* id_stage.sv */
/*
 * instruction decode: two-view decoder, register file with write-through,
 * read-after-write interlock, halt detection, decode register
 */
`default_nettype none

module id_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  cpu_pipe_pkg::if_id_t   if_id,
    input  wire                    ex_ready,
    input  cpu_pipe_pkg::hazard_t  ex_haz,
    input  cpu_pipe_pkg::hazard_t  mem_haz,
    input  cpu_pipe_pkg::wb_wr_t   wb_wr,
    output cpu_pipe_pkg::id_ex_t   id_ex,
    output logic                   id_ready,
    output logic                   halted
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [XLEN-1:0]   gpr [NREGS];
    instr_t            ins;
    logic              rtype;
    logic [REG_AW-1:0] src_a;
    logic [REG_AW-1:0] src_b;
    logic [XLEN-1:0]   rdata_a;
    logic [XLEN-1:0]   rdata_b;
    logic              use_a;
    logic              use_b;
    logic              is_halt;
    logic              stall;
    logic              id_ex_load;
    logic              consume;
    logic              issue;
    logic              halt_q;
    id_ex_t            id_ex_d;

    // register read, retiring value wins, r0 fixed at zero
    function automatic logic [XLEN-1:0] gpr_rd(input logic [REG_AW-1:0] a);
        if (a == '0) begin
            return '0;
        end
        if (wb_wr.we && wb_wr.addr == a) begin
            return wb_wr.data;
        end
        return gpr[a];
    endfunction

    function automatic logic haz_hit(input hazard_t h, input logic [REG_AW-1:0] src,
                                     input logic use_src);
        return use_src && src != '0 && h.valid && h.gpr_we && h.dst_addr == src;
    endfunction

    // all registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NREGS; k++) begin
                gpr[k] <= '0;
            end
        end else if (wb_wr.we && wb_wr.addr != '0) begin
            gpr[wb_wr.addr] <= wb_wr.data;
        end
    end

    assign ins   = if_id.instr;
    assign rtype = ins.r.opcode == OP_RTYPE;
    assign src_a = ins.r.rs1;
    // sw names its data register in rd
    assign src_b = rtype ? ins.r.rs2 : ins.i.rd;

    always_comb begin
        rdata_a = gpr_rd(src_a);
        rdata_b = gpr_rd(src_b);
    end

    always_comb begin
        id_ex_d             = '0;
        id_ex_d.alu_op      = ALU_ADD;
        id_ex_d.ex_out_sel  = EX_OUT_ALU;
        id_ex_d.alu_in0     = rdata_a;
        // sign-extended immediate by default
        id_ex_d.alu_in1     = {{(XLEN-16){ins.i.imm[15]}}, ins.i.imm};
        id_ex_d.mem_op      = MEM_NONE;
        id_ex_d.mem_wr_data = rdata_b;
        id_ex_d.dst_addr    = ins.i.rd;
        use_a               = 1'b1;
        use_b               = 1'b0;
        is_halt             = 1'b0;
        case (ins.r.opcode)
            OP_RTYPE: begin
                id_ex_d.alu_op   = alu_op_t'(ins.r.func[2:0]);
                id_ex_d.alu_in1  = rdata_b;
                id_ex_d.dst_addr = ins.r.rd;
                id_ex_d.gpr_we   = 1'b1;
                use_b            = 1'b1;
            end
            OP_ADDI: id_ex_d.gpr_we = 1'b1;
            OP_ORI: begin
                id_ex_d.alu_op  = ALU_OR;
                id_ex_d.alu_in1 = {{(XLEN-16){1'b0}}, ins.i.imm};
                id_ex_d.gpr_we  = 1'b1;
            end
            OP_LW: begin
                id_ex_d.mem_op = MEM_LOAD;
                id_ex_d.gpr_we = 1'b1;
            end
            OP_SW: begin
                id_ex_d.mem_op = MEM_STORE;
                use_b          = 1'b1;
            end
            OP_HALT: begin
                is_halt = 1'b1;
                use_a   = 1'b0;
            end
            // unknown opcode runs as a nop
            default: use_a = 1'b0;
        endcase
    end

    // older writers still in execute or memory
    assign stall = haz_hit(ex_haz, src_a, use_a) || haz_hit(ex_haz, src_b, use_b) ||
                   haz_hit(mem_haz, src_a, use_a) || haz_hit(mem_haz, src_b, use_b);

    assign id_ex_load = !id_ex.valid || ex_ready;
    assign id_ready   = !stall && !halt_q && id_ex_load;
    assign consume    = if_id.valid && id_ready;
    // halt itself leaves a bubble
    assign issue      = consume && !is_halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex  <= '0;
            halt_q <= 1'b0;
            halted <= 1'b0;
        end else begin
            if (id_ex_load) begin
                id_ex       <= id_ex_d;
                id_ex.valid <= issue;
            end
            if (consume && is_halt) begin
                halt_q <= 1'b1;
            end
            // wait for execute and memory to drain
            halted <= halt_q && !ex_haz.valid && !mem_haz.valid;
        end
    end

endmodule

`default_nettype wire

/* ex_stage.sv */
/*
 * execute: eight-function alu, output select, execute register
 * and the bypass record for the instruction being executed
 */
`default_nettype none

module ex_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  cpu_pipe_pkg::id_ex_t   id_ex,
    input  wire                    mem_ready,
    output cpu_pipe_pkg::ex_mem_t  ex_mem,
    output cpu_pipe_pkg::hazard_t  ex_haz,
    output logic                   ex_ready
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] ex_out_in;
    logic [4:0]      shamt;

    // shifts take the low five bits only
    assign shamt = id_ex.alu_in1[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_out = id_ex.alu_in0 + id_ex.alu_in1;
            ALU_SUB: alu_out = id_ex.alu_in0 - id_ex.alu_in1;
            ALU_AND: alu_out = id_ex.alu_in0 & id_ex.alu_in1;
            ALU_OR:  alu_out = id_ex.alu_in0 | id_ex.alu_in1;
            ALU_XOR: alu_out = id_ex.alu_in0 ^ id_ex.alu_in1;
            ALU_SLL: alu_out = id_ex.alu_in0 << shamt;
            ALU_SRL: alu_out = id_ex.alu_in0 >> shamt;
            // signed compare, result in bit 0
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}},
                                $signed(id_ex.alu_in0) < $signed(id_ex.alu_in1)};
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (id_ex.ex_out_sel)
            EX_OUT_ALU:  ex_out_in = alu_out;
            EX_OUT_PASS: ex_out_in = id_ex.alu_in1;
            default:     ex_out_in = alu_out;
        endcase
    end

    // register loads when empty or its content retires
    assign ex_ready = !ex_mem.valid || mem_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (ex_ready) begin
            ex_mem.valid       <= id_ex.valid;
            ex_mem.ex_out      <= ex_out_in;
            ex_mem.mem_op      <= id_ex.mem_op;
            ex_mem.mem_wr_data <= id_ex.mem_wr_data;
            ex_mem.dst_addr    <= id_ex.dst_addr;
            ex_mem.gpr_we      <= id_ex.gpr_we;
        end
    end

    // bypass out for the decode interlock
    assign ex_haz.valid    = id_ex.valid;
    assign ex_haz.dst_addr = id_ex.dst_addr;
    assign ex_haz.gpr_we   = id_ex.gpr_we;

endmodule

`default_nettype wire

/* mem_stage.sv */
/*
 * memory access and write-back: load and store over wishbone,
 * retirement into the register file, hazard record for decode
 */
`default_nettype none

module mem_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  cpu_pipe_pkg::ex_mem_t  ex_mem,
    output cpu_pipe_pkg::wb_req_t  bus_req,
    input  cpu_pipe_pkg::wb_rsp_t  bus_rsp,
    output cpu_pipe_pkg::wb_wr_t   wb_wr,
    output cpu_pipe_pkg::hazard_t  mem_haz,
    output logic                   mem_ready
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic busy_q;
    logic is_mem;
    logic ack;
    logic retire;

    assign is_mem = ex_mem.valid && ex_mem.mem_op != MEM_NONE;
    assign ack    = bus_rsp.ack && busy_q;
    // alu result retires at once, memory ops on ack
    assign retire    = ex_mem.valid && (!is_mem || ack);
    assign mem_ready = !ex_mem.valid || retire;

    // one access per instruction, ex_mem holds until ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (ack) begin
            busy_q <= 1'b0;
        end else if (is_mem) begin
            busy_q <= 1'b1;
        end
    end

    assign bus_req.cyc   = busy_q;
    assign bus_req.stb   = busy_q;
    assign bus_req.we    = ex_mem.mem_op == MEM_STORE;
    assign bus_req.adr   = ex_mem.ex_out[ADDR_W-1:0];
    assign bus_req.dat_w = ex_mem.mem_wr_data;

    assign wb_wr.we   = retire && ex_mem.gpr_we;
    assign wb_wr.addr = ex_mem.dst_addr;
    assign wb_wr.data = (ex_mem.mem_op == MEM_LOAD) ? bus_rsp.dat_r : ex_mem.ex_out;

    // cleared while retiring, decode sees the value via write-through
    assign mem_haz.valid    = ex_mem.valid && !retire;
    assign mem_haz.dst_addr = ex_mem.dst_addr;
    assign mem_haz.gpr_we   = ex_mem.gpr_we;

endmodule

`default_nettype wire

/* wb_arbiter.sv */
/*
 * two-master wishbone classic arbiter, fixed priority to m0,
 * grant locked to its owner for the whole cycle
 */
`default_nettype none

module wb_arbiter (
    input  wire                    clk,
    input  wire                    rst_n,
    input  cpu_pipe_pkg::wb_req_t  m0_req,
    output cpu_pipe_pkg::wb_rsp_t  m0_rsp,
    input  cpu_pipe_pkg::wb_req_t  m1_req,
    output cpu_pipe_pkg::wb_rsp_t  m1_rsp,
    output cpu_pipe_pkg::wb_req_t  s_req,
    input  cpu_pipe_pkg::wb_rsp_t  s_rsp
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_M0,
        OWN_M1
    } owner_t;

    owner_t owner_q;
    owner_t grant;

    // current owner keeps the bus while cyc is high
    always_comb begin
        if (owner_q == OWN_M0 && m0_req.cyc) begin
            grant = OWN_M0;
        end else if (owner_q == OWN_M1 && m1_req.cyc) begin
            grant = OWN_M1;
        end else if (m0_req.cyc) begin
            grant = OWN_M0;
        end else if (m1_req.cyc) begin
            grant = OWN_M1;
        end else begin
            grant = OWN_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= grant;
        end
    end

    always_comb begin
        case (grant)
            OWN_M0:  s_req = m0_req;
            OWN_M1:  s_req = m1_req;
            default: s_req = '0;
        endcase
    end

    // ack only to the owner, read data shared
    assign m0_rsp.ack   = s_rsp.ack && grant == OWN_M0;
    assign m0_rsp.dat_r = s_rsp.dat_r;
    assign m1_rsp.ack   = s_rsp.ack && grant == OWN_M1;
    assign m1_rsp.dat_r = s_rsp.dat_r;

endmodule

`default_nettype wire

/* cpu_top.sv */
/*
 * core top level: four pipeline stages and the bus arbiter
 */
`default_nettype none

module cpu_top (
    input  wire                    clk,
    input  wire                    rst_n,
    output cpu_pipe_pkg::wb_req_t  wb_req,
    input  cpu_pipe_pkg::wb_rsp_t  wb_rsp,
    output logic                   halted
);
    import cpu_pipe_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    hazard_t ex_haz;
    hazard_t mem_haz;
    wb_wr_t  wb_wr;
    // per-master bus sides
    wb_req_t if_req;
    wb_rsp_t if_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;
    logic    id_ready;
    logic    ex_ready;
    logic    mem_ready;

    if_stage u_if (
        .clk      (clk),
        .rst_n    (rst_n),
        .halted   (halted),
        .id_ready (id_ready),
        .bus_req  (if_req),
        .bus_rsp  (if_rsp),
        .if_id    (if_id)
    );

    id_stage u_id (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_id    (if_id),
        .ex_ready (ex_ready),
        .ex_haz   (ex_haz),
        .mem_haz  (mem_haz),
        .wb_wr    (wb_wr),
        .id_ex    (id_ex),
        .id_ready (id_ready),
        .halted   (halted)
    );

    ex_stage u_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_ex     (id_ex),
        .mem_ready (mem_ready),
        .ex_mem    (ex_mem),
        .ex_haz    (ex_haz),
        .ex_ready  (ex_ready)
    );

    mem_stage u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem),
        .bus_req   (mem_req),
        .bus_rsp   (mem_rsp),
        .wb_wr     (wb_wr),
        .mem_haz   (mem_haz),
        .mem_ready (mem_ready)
    );

    // memory stage is m0 and wins ties
    wb_arbiter u_arb (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_req (mem_req),
        .m0_rsp (mem_rsp),
        .m1_req (if_req),
        .m1_rsp (if_rsp),
        .s_req  (wb_req),
        .s_rsp  (wb_rsp)
    );

endmodule

`default_nettype wire

/* cpu_chk.sv */
/*
 * bound assertions: wishbone request rules, idle bus in reset
 */
`default_nettype none

module cpu_chk (
    input wire                    clk,
    input wire                    rst_n,
    input cpu_pipe_pkg::wb_req_t  wb_req,
    input cpu_pipe_pkg::wb_rsp_t  wb_rsp,
    input wire                    halted
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int fail_count = 0;

    // stb only inside a cycle
    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc)
        else begin
            $error("wishbone stb high without cyc");
            fail_count++;
        end

    // waiting master keeps its request steady
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr) &&
                                      $stable(wb_req.we) && $stable(wb_req.dat_w))
        else begin
            $error("wishbone request changed or dropped before ack");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |-> !wb_req.cyc && !wb_req.stb && !halted)
        else begin
            $error("bus or halted active during reset");
            fail_count++;
        end

    a_reset_exit: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_req.cyc && !wb_req.stb && !halted)
        else begin
            $error("bus or halted active right after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb_cpu.sv */
/*
 * core testbench: clock and reset, random program with a reference
 * model, wishbone memory with random ack delay, fetch and store checks
 */
`default_nettype none

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int N_INSTR = 200;
    localparam int N_DATA = 64;
    localparam logic [ADDR_W-1:0] DATA_BASE = 16'h8000;
    localparam int WATCHDOG_CYCLES = N_INSTR * 40;
    localparam int QUIET_CYCLES = 50;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    halted;

    // 64k-word bus memory, code from 0, data at DATA_BASE
    logic [XLEN-1:0]   mem [0:(1 << ADDR_W) - 1];
    logic [XLEN-1:0]   model_data [N_DATA];
    instr_t            prog [N_INSTR + 1];
    logic [ADDR_W-1:0] exp_st_adr [$];
    logic [XLEN-1:0]   exp_st_dat [$];
    int unsigned       ack_delay [1024];
    logic [ADDR_W-1:0] exp_pc;
    int                n_acc;
    int                err_fetch;
    int                err_store;
    int                err_mem;
    int                err_bus;

    cpu_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .halted (halted)
    );

    bind cpu_top cpu_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // background contents, every address bit matters
    function automatic logic [XLEN-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return {a ^ 16'hc3a5, ~a};
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input alu_op_t op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // registers r0..r7 only, so hazards come often
    function automatic instr_t rand_instr();
        instr_t      w;
        int unsigned kind;
        kind = $urandom_range(9, 0);
        w    = '0;
        if (kind <= 3) begin
            w.r.opcode = OP_RTYPE;
            w.r.rd     = 5'($urandom_range(7, 0));
            w.r.rs1    = 5'($urandom_range(7, 0));
            w.r.rs2    = 5'($urandom_range(7, 0));
            w.r.func   = 11'($urandom_range(7, 0));
        end else if (kind <= 5) begin
            w.i.opcode = (kind == 4) ? OP_ADDI : OP_ORI;
            w.i.rd     = 5'($urandom_range(7, 1));
            w.i.rs1    = 5'($urandom_range(7, 0));
            w.i.imm    = 16'($urandom);
        end else begin
            // r0 base, imm picks the data word
            w.i.opcode = (kind == 6) ? OP_LW : OP_SW;
            w.i.rd     = 5'($urandom_range(7, 0));
            w.i.rs1    = '0;
            w.i.imm    = DATA_BASE | 16'($urandom_range(N_DATA - 1, 0));
        end
        return w;
    endfunction

    // instruction-level reference, one instruction at a time
    task automatic run_model();
        logic [XLEN-1:0]   regs [NREGS];
        instr_t            w;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   simm;
        logic [XLEN-1:0]   res;
        logic [ADDR_W-1:0] adr;
        logic              wr;
        int                pc;
        foreach (regs[k]) regs[k] = '0;
        foreach (model_data[k]) model_data[k] = fill_word(DATA_BASE + ADDR_W'(k));
        for (pc = 0; pc < N_INSTR; pc++) begin
            w    = prog[pc];
            a    = regs[w.r.rs1];
            simm = {{(XLEN-16){w.i.imm[15]}}, w.i.imm};
            adr  = ADDR_W'(a + simm);
            res  = '0;
            wr   = 1'b1;
            case (w.r.opcode)
                OP_RTYPE: res = alu_ref(alu_op_t'(w.r.func[2:0]), a, regs[w.r.rs2]);
                OP_ADDI:  res = a + simm;
                OP_ORI:   res = a | {{(XLEN-16){1'b0}}, w.i.imm};
                OP_LW:    res = model_data[adr - DATA_BASE];
                OP_SW: begin
                    exp_st_adr.push_back(adr);
                    exp_st_dat.push_back(regs[w.i.rd]);
                    model_data[adr - DATA_BASE] = regs[w.i.rd];
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w.r.rd != '0) begin
                regs[w.r.rd] = res;
            end
        end
    endtask

    // the request seen at stb must stay put until ack
    task automatic hold_check(input wb_req_t req);
        if (!wb_req.stb) begin
            $display("bus error: stb dropped before ack at %0t", $time);
            err_bus++;
        end else if (wb_req !== req) begin
            $display("CHECK FAILED wb_req: expected %h, got %h", req, wb_req);
            err_bus++;
        end
    endtask

    task automatic serve(input wb_req_t req);
        logic [ADDR_W-1:0] ea;
        logic [XLEN-1:0]   ed;
        if (req.we) begin
            if (exp_st_adr.size() == 0) begin
                $display("extra store to %h with data %h", req.adr, req.dat_w);
                err_store++;
            end else begin
                ea = exp_st_adr.pop_front();
                ed = exp_st_dat.pop_front();
                if (req.adr !== ea) begin
                    $display("CHECK FAILED wb_req.adr (store): expected %h, got %h", ea, req.adr);
                    err_store++;
                end
                if (req.dat_w !== ed) begin
                    $display("CHECK FAILED wb_req.dat_w: expected %h, got %h", ed, req.dat_w);
                    err_store++;
                end
            end
            mem[req.adr] = req.dat_w;
        end else begin
            // reads below DATA_BASE are fetches
            if (req.adr < DATA_BASE) begin
                if (req.adr !== exp_pc) begin
                    $display("CHECK FAILED wb_req.adr (fetch): expected %h, got %h",
                             exp_pc, req.adr);
                    err_fetch++;
                end
                exp_pc = exp_pc + 1'b1;
            end
            wb_rsp.dat_r = mem[req.adr];
        end
    endtask

    task automatic report_counts();
        $display("errors: fetch %0d, store %0d, memory %0d, bus %0d, assertion %0d",
                 err_fetch, err_store, err_mem, err_bus, DUT.u_chk.fail_count);
    endtask

    // sample mid-cycle, answer 1 ns after the edge
    initial begin : bus_memory
        wb_req_t     req;
        int unsigned dly;
        wb_rsp = '0;
        n_acc  = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (wb_req.stb) begin
                req = wb_req;
                dly = ack_delay[n_acc % 1024];
                n_acc++;
                repeat (dly) begin
                    @(negedge clk);
                    hold_check(req);
                end
                @(posedge clk);
                #1;
                serve(req);
                wb_rsp.ack = 1'b1;
                @(negedge clk);
                hold_check(req);
                @(posedge clk);
                #1;
                wb_rsp.ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: halted not reached within %0d cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int i;
        void'($urandom(32'h2197));
        rst_n     = 1'b0;
        err_fetch = 0;
        err_store = 0;
        err_mem   = 0;
        err_bus   = 0;
        exp_pc    = RESET_PC;
        for (i = 0; i < 1024; i++) begin
            ack_delay[i] = $urandom_range(3, 0);
        end
        for (i = 0; i < N_INSTR; i++) begin
            prog[i] = rand_instr();
        end
        prog[N_INSTR]          = '0;
        prog[N_INSTR].i.opcode = OP_HALT;
        run_model();
        for (i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = fill_word(ADDR_W'(i));
        end
        for (i = 0; i <= N_INSTR; i++) begin
            mem[RESET_PC + i] = prog[i];
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (halted === 1'b1);
        // a prefetch already on the bus may still finish
        @(negedge clk);
        while (wb_req.cyc) @(negedge clk);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (wb_req.cyc || wb_req.stb) begin
                $display("bus request after halt at %0t", $time);
                err_bus++;
            end
        end
        if (exp_st_adr.size() != 0) begin
            $display("%0d expected stores never reached the bus", exp_st_adr.size());
            err_store += exp_st_adr.size();
        end
        for (i = 0; i < N_DATA; i++) begin
            if (mem[DATA_BASE + i] !== model_data[i]) begin
                $display("CHECK FAILED mem[%h]: expected %h, got %h",
                         DATA_BASE + ADDR_W'(i), model_data[i], mem[DATA_BASE + i]);
                err_mem++;
            end
        end
        report_counts();
        if (err_fetch + err_store + err_mem + err_bus + DUT.u_chk.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
if_stage.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
wb_arbiter.sv
cpu_top.sv
cpu_chk.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_isa_pkg.sv
  - cpu_pipe_pkg.sv
  - if_stage.sv
  - id_stage.sv
  - ex_stage.sv
  - mem_stage.sv
  - wb_arbiter.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_chk.sv
      - tb_cpu.sv
